// File: all.f
src/core_pkg.sv
src/rename_pkg.sv
src/skid_buffer.sv
src/rename_lane.sv
src/rename_map.sv
src/free_list.sv
src/rename_stage.sv
testbench/tb_rename_stage.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module tb_rename_stage -o sim_rename \
    && ./obj_dir/sim_rename \
    || exit 1

// File: src/core_pkg.sv
// ====================================================================
// ISA-side types of the rename stage
// lane 0 is the oldest micro-op of a group, lane 1 follows it
// register count and group width are fixed at elaboration
// ====================================================================
package core_pkg;

    localparam int arch_regs   = 8;
    localparam int arch_w      = 3;
    localparam int group_width = 2;

    // wide enough to count every destination in one group
    localparam int dest_cnt_w = $clog2(group_width + 1);

    typedef logic [arch_w-1:0] arch_reg_t;
    typedef logic [3:0]        opcode_t;
    typedef logic [8:0]        imm_t;

    // one logical micro-op, 24 bits
    typedef struct packed {
        logic      valid;
        opcode_t   opcode;
        logic      has_dest;
        arch_reg_t dest;
        arch_reg_t src1;
        arch_reg_t src2;
        imm_t      imm;
    } uop_t;

    // input payload, index 0 is lane 0
    typedef uop_t [group_width-1:0] uop_group_t;

endpackage

// File: src/free_list.sv
// ====================================================================
// free mask of physical tags
// a release sets its bit from the next edge on, so a tag released
// in the same cycle as a fire is not handed out in that cycle
// enough compares the current free count with the group's need
// ====================================================================
`timescale 1ns/10ps

module free_list (
    input  logic                            clk,
    input  logic                            rst,
    output rename_pkg::free_mask_t          mask,
    input  rename_pkg::free_mask_t          next_mask,
    input  logic                            load,
    input  logic [core_pkg::dest_cnt_w-1:0] need,
    output logic                            enough,
    input  rename_pkg::release_t            tag_release
);

    logic [rename_pkg::phys_w:0] free_cnt;
    rename_pkg::free_mask_t      mask_next;

    // population count of the free mask
    always_comb begin
        free_cnt = '0;
        for (int t = 0; t < rename_pkg::phys_regs; t++) begin
            free_cnt = free_cnt + {{rename_pkg::phys_w{1'b0}}, mask[t]};
        end
    end

    assign enough = (free_cnt >= need);

    always_comb begin
        mask_next = load ? next_mask : mask;
        if (tag_release.valid) begin
            mask_next[tag_release.tag] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // tags below arch_regs back the reset mapping
            mask <= ~rename_pkg::free_mask_t'((1 << core_pkg::arch_regs) - 1);
        end else begin
            mask <= mask_next;
        end
    end

    // retirement only returns tags that are in use
    assert property (@(posedge clk) disable iff (rst)
        tag_release.valid |-> !mask[tag_release.tag])
        else $error("free_list release of a tag that is already free");

endmodule

// File: src/rename_lane.sv
// ====================================================================
// combinational rename of one micro-op
// map and free mask come chained from the previous lane, so sources
// see the tags handed out by older lanes of the same group
// the caller must only mark a lane valid when tags are available
// ====================================================================
`timescale 1ns/10ps

module rename_lane (
    input  core_pkg::uop_t            uop,
    input  rename_pkg::map_table_t    map_in,
    input  rename_pkg::free_mask_t    mask_in,
    output rename_pkg::map_table_t    map_out,
    output rename_pkg::free_mask_t    mask_out,
    output rename_pkg::renamed_uop_t  renamed
);

    logic                  writes;
    logic                  found;
    rename_pkg::phys_tag_t new_tag;

    assign writes = uop.valid && uop.has_dest;

    // lowest free tag wins
    always_comb begin
        found   = 1'b0;
        new_tag = '0;
        for (int t = 0; t < rename_pkg::phys_regs; t++) begin
            if (!found && mask_in[t]) begin
                found   = 1'b1;
                new_tag = t[rename_pkg::phys_w-1:0];
            end
        end
    end

    always_comb begin
        map_out  = map_in;
        mask_out = mask_in;

        renamed.valid      = uop.valid;
        renamed.opcode     = uop.opcode;
        renamed.has_dest   = uop.has_dest;
        renamed.dest_arch  = uop.dest;
        renamed.dest_tag   = '0;
        renamed.old_tag    = '0;
        // sources are read before this lane's own write
        renamed.src1_tag   = map_in[uop.src1].tag;
        renamed.src1_ready = map_in[uop.src1].ready;
        renamed.src2_tag   = map_in[uop.src2].tag;
        renamed.src2_ready = map_in[uop.src2].ready;
        renamed.imm        = uop.imm;

        if (writes) begin
            renamed.dest_tag       = new_tag;
            renamed.old_tag        = map_in[uop.dest].tag;
            map_out[uop.dest].tag   = new_tag;
            map_out[uop.dest].ready = 1'b0;
            mask_out[new_tag]      = 1'b0;
        end
    end

    // the enough check upstream must keep a tag available
    always_comb begin
        assert final (!writes || (mask_in != '0))
            else $error("rename_lane allocation from an empty free mask");
    end

endmodule

// File: src/rename_map.sv
// ====================================================================
// register alias table with one tag and ready flag per arch register
// a completion marks every entry that still names its tag once the
// group load of the same edge is applied
// ====================================================================
`timescale 1ns/10ps

module rename_map (
    input  logic                   clk,
    input  logic                   rst,
    output rename_pkg::map_table_t map,
    input  rename_pkg::map_table_t next_map,
    input  logic                   load,
    input  rename_pkg::complete_t  complete
);

    rename_pkg::map_table_t map_next;
    logic                   aliased;

    always_comb begin
        map_next = load ? next_map : map;
        if (complete.valid) begin
            for (int r = 0; r < core_pkg::arch_regs; r++) begin
                // entries already renamed past this tag stay not ready
                if (map_next[r].tag == complete.tag) begin
                    map_next[r].ready = 1'b1;
                end
            end
        end
    end

    // any two arch registers naming the same tag
    always_comb begin
        aliased = 1'b0;
        for (int a = 0; a < core_pkg::arch_regs; a++) begin
            for (int b = a + 1; b < core_pkg::arch_regs; b++) begin
                if (map[a].tag == map[b].tag) begin
                    aliased = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // identity mapping with every entry ready
            for (int r = 0; r < core_pkg::arch_regs; r++) begin
                map[r].tag   <= r[rename_pkg::phys_w-1:0];
                map[r].ready <= 1'b1;
            end
        end else begin
            map <= map_next;
        end
    end

    // a loaded group never maps two arch registers to one tag
    assert property (@(posedge clk) disable iff (rst)
        load |=> !aliased)
        else $error("rename_map aliased tag after load");

endmodule

// File: src/rename_pkg.sv
// ====================================================================
// rename-side types: physical tags, map entries, renamed micro-ops
// tags 0 to arch_regs-1 hold the reset mapping, the rest start free
// a free mask bit that is set marks a free tag
// ====================================================================
package rename_pkg;

    localparam int phys_regs = 32;
    localparam int phys_w    = 5;

    typedef logic [phys_w-1:0]    phys_tag_t;
    typedef logic [phys_regs-1:0] free_mask_t;

    typedef struct packed {
        phys_tag_t tag;
        logic      ready;
    } map_entry_t;

    // indexed by architectural register number
    typedef map_entry_t [core_pkg::arch_regs-1:0] map_table_t;

    typedef struct packed {
        logic                valid;
        core_pkg::opcode_t   opcode;
        logic                has_dest;
        core_pkg::arch_reg_t dest_arch;
        phys_tag_t           dest_tag;
        // tag to free once this micro-op retires
        phys_tag_t           old_tag;
        phys_tag_t           src1_tag;
        logic                src1_ready;
        phys_tag_t           src2_tag;
        logic                src2_ready;
        core_pkg::imm_t      imm;
    } renamed_uop_t;

    typedef renamed_uop_t [core_pkg::group_width-1:0] renamed_group_t;

    // a producer that finished, its tag becomes ready
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
    } complete_t;

    // an old tag handed back by retirement
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
    } release_t;

endpackage

// File: src/rename_stage.sv
// ====================================================================
// rename stage top with input buffer, lane chain, map, free list and
// output buffer
// one fire renames both lanes of a group
// a group waits in the input buffer until enough tags are free
// no reorder buffer, no recovery, no checkpoints
// ====================================================================
`timescale 1ns/10ps

module rename_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  core_pkg::uop_group_t       in_group,
    input  logic                       in_valid,
    output logic                       in_ready,
    output rename_pkg::renamed_group_t out_group,
    output logic                       out_valid,
    input  logic                       out_ready,
    input  rename_pkg::complete_t      complete,
    input  rename_pkg::release_t       tag_release
);

    core_pkg::uop_group_t            head_group;
    logic                            head_valid;
    logic                            out_buf_ready;
    logic                            enough;
    logic                            fire;
    core_pkg::uop_t                  lane_uop   [core_pkg::group_width];
    rename_pkg::map_table_t          map_chain  [core_pkg::group_width+1];
    rename_pkg::free_mask_t          mask_chain [core_pkg::group_width+1];
    logic [core_pkg::dest_cnt_w-1:0] dest_cnt   [core_pkg::group_width+1];
    rename_pkg::renamed_group_t      renamed_group;

    skid_buffer #(.payload_t(core_pkg::uop_group_t)) u_in_buf (
        .clk(clk), .rst(rst),
        .in_data(in_group), .in_valid(in_valid), .in_ready(in_ready),
        .out_data(head_group), .out_valid(head_valid), .out_ready(fire)
    );

    assign fire        = head_valid && out_buf_ready && enough;
    assign dest_cnt[0] = '0;

    genvar i;
    generate
        for (i = 0; i < core_pkg::group_width; i++) begin : g_lane
            // lanes only allocate on a firing group
            assign lane_uop[i] = {head_group[i].valid & fire,
                                  head_group[i][$bits(core_pkg::uop_t)-2:0]};
            assign dest_cnt[i+1] = dest_cnt[i]
                + {{(core_pkg::dest_cnt_w-1){1'b0}},
                   head_group[i].valid & head_group[i].has_dest};

            rename_lane u_lane (
                .uop(lane_uop[i]), .map_in(map_chain[i]), .mask_in(mask_chain[i]),
                .map_out(map_chain[i+1]), .mask_out(mask_chain[i+1]),
                .renamed(renamed_group[i])
            );
        end
    endgenerate

    rename_map u_map (
        .clk(clk), .rst(rst), .map(map_chain[0]),
        .next_map(map_chain[core_pkg::group_width]),
        .load(fire), .complete(complete)
    );

    free_list u_free (
        .clk(clk), .rst(rst), .mask(mask_chain[0]),
        .next_mask(mask_chain[core_pkg::group_width]),
        .load(fire), .need(dest_cnt[core_pkg::group_width]), .enough(enough),
        .tag_release(tag_release)
    );

    skid_buffer #(.payload_t(rename_pkg::renamed_group_t)) u_out_buf (
        .clk(clk), .rst(rst),
        .in_data(renamed_group), .in_valid(fire), .in_ready(out_buf_ready),
        .out_data(out_group), .out_valid(out_valid), .out_ready(out_ready)
    );

endmodule

// File: src/skid_buffer.sv
// ====================================================================
// two-entry valid/ready buffer with the payload type set by parameter
// one edge of latency and in_ready drops only when both entries are full
// out_data holds while out_valid is high and out_ready is low
// ====================================================================
`timescale 1ns/10ps

module skid_buffer #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t   mem [2];
    logic       rd_ptr;
    logic       wr_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    // head entry straight from storage
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= 1'b0;
            wr_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    // pointers differ exactly when one entry is held
    assert property (@(posedge clk) disable iff (rst)
        (count == 2'd1) == (rd_ptr != wr_ptr))
        else $error("skid_buffer pointers disagree with occupancy");

    // a stalled head stays put until it is taken
    assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("skid_buffer output changed while stalled");

endmodule

// File: testbench/tb_rename_stage.sv
// ======================================================================
// testbench for the rename stage, one table step applied per loop pass
// a reference map and free mask predict every renamed group
// completions and releases are applied while the stage is idle
// stops at the first error
// ======================================================================
`timescale 1ns/10ps

module tb_rename_stage;

    localparam int reset_cycles = 10;

    logic                       clk;
    logic                       rst;
    core_pkg::uop_group_t       in_group;
    logic                       in_valid;
    logic                       in_ready;
    rename_pkg::renamed_group_t out_group;
    logic                       out_valid;
    logic                       out_ready;
    rename_pkg::complete_t      complete;
    rename_pkg::release_t       tag_release;

    // stimulus table
    string                      step_name  [$];
    core_pkg::uop_group_t       step_group [$];
    rename_pkg::complete_t      step_cmp   [$];
    rename_pkg::release_t       step_rel   [$];
    bit                         step_hold  [$];
    int                         tags_left = 24;

    // reference model and expected outputs
    rename_pkg::map_table_t     model_map;
    rename_pkg::free_mask_t     model_mask;
    rename_pkg::renamed_group_t exp_q      [$];
    string                      exp_name   [$];
    rename_pkg::renamed_group_t last_group;
    rename_pkg::renamed_group_t held_group;
    logic                       stalled;
    int                         cycles = 0;
    int                         limit  = 1000;

    rename_stage uut (
        .clk(clk), .rst(rst),
        .in_group(in_group), .in_valid(in_valid), .in_ready(in_ready),
        .out_group(out_group), .out_valid(out_valid), .out_ready(out_ready),
        .complete(complete), .tag_release(tag_release)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_group(string name, rename_pkg::renamed_group_t exp,
                               rename_pkg::renamed_group_t act);
        if (act !== exp) begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_tag(string name, rename_pkg::phys_tag_t exp,
                             rename_pkg::phys_tag_t act);
        if (act !== exp) begin
            $display("Mismatch %s expected %0d actual %0d", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Mismatch %s expected %0b actual %0b", name, exp, act);
            stop_on_error();
        end
    endtask

    // hang guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout: the run went past %0d cycles", limit);
            stop_on_error();
        end
    end

    // sampled mid-cycle, a transfer happens at the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (stalled && out_valid) begin
                check_group("output hold", held_group, out_group);
            end
            stalled    = out_valid && !out_ready;
            held_group = out_group;
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("the stage sent a group that no step expected");
                    stop_on_error();
                end
                check_group(exp_name.pop_front(), exp_q.pop_front(), out_group);
                last_group = out_group;
            end
        end
    end

    function automatic core_pkg::uop_t make_uop(logic hd, core_pkg::arch_reg_t d,
                                                core_pkg::arch_reg_t s1,
                                                core_pkg::arch_reg_t s2,
                                                core_pkg::opcode_t op);
        core_pkg::uop_t u;
        logic [31:0]    rnd;
        rnd        = $urandom;
        u.valid    = 1'b1;
        u.opcode   = op;
        u.has_dest = hd;
        u.dest     = d;
        u.src1     = s1;
        u.src2     = s2;
        u.imm      = rnd[8:0];
        return u;
    endfunction

    function automatic int dest_count(core_pkg::uop_group_t g);
        int n;
        n = 0;
        for (int l = 0; l < core_pkg::group_width; l++) begin
            if (g[l].valid && g[l].has_dest) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic int free_count();
        int n;
        n = 0;
        for (int t = 0; t < rename_pkg::phys_regs; t++) begin
            if (model_mask[t]) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic rename_pkg::phys_tag_t lowest_free();
        rename_pkg::phys_tag_t tag;
        tag = '0;
        for (int t = rename_pkg::phys_regs - 1; t >= 0; t--) begin
            if (model_mask[t]) begin
                tag = rename_pkg::phys_tag_t'(t);
            end
        end
        return tag;
    endfunction

    // rename rules applied lane by lane on the model state
    task automatic queue_expected(string name, core_pkg::uop_group_t g);
        rename_pkg::renamed_group_t r;
        rename_pkg::phys_tag_t      t;
        for (int l = 0; l < core_pkg::group_width; l++) begin
            r[l].valid      = g[l].valid;
            r[l].opcode     = g[l].opcode;
            r[l].has_dest   = g[l].has_dest;
            r[l].dest_arch  = g[l].dest;
            r[l].dest_tag   = '0;
            r[l].old_tag    = '0;
            r[l].src1_tag   = model_map[g[l].src1].tag;
            r[l].src1_ready = model_map[g[l].src1].ready;
            r[l].src2_tag   = model_map[g[l].src2].tag;
            r[l].src2_ready = model_map[g[l].src2].ready;
            r[l].imm        = g[l].imm;
            if (g[l].valid && g[l].has_dest) begin
                t                          = lowest_free();
                r[l].dest_tag              = t;
                r[l].old_tag               = model_map[g[l].dest].tag;
                model_map[g[l].dest].tag   = t;
                model_map[g[l].dest].ready = 1'b0;
                model_mask[t]              = 1'b0;
            end
        end
        exp_q.push_back(r);
        exp_name.push_back(name);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic send_group(core_pkg::uop_group_t g);
        in_group = g;
        in_valid = 1'b1;
        while (!in_ready) begin
            next_cycle();
        end
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic apply_complete(rename_pkg::complete_t c);
        complete = c;
        for (int r = 0; r < core_pkg::arch_regs; r++) begin
            if (model_map[r].tag == c.tag) begin
                model_map[r].ready = 1'b1;
            end
        end
        next_cycle();
        complete = '0;
    endtask

    task automatic apply_release(rename_pkg::release_t r);
        tag_release        = r;
        model_mask[r.tag]  = 1'b1;
        next_cycle();
        tag_release = '0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            next_cycle();
        end
    endtask

    task automatic add_step(string name, core_pkg::uop_t a, core_pkg::uop_t b,
                            logic [5:0] cmp, logic [5:0] rel, bit hold);
        core_pkg::uop_group_t g;
        g[0] = a;
        g[1] = b;
        step_name.push_back(name);
        step_group.push_back(g);
        step_cmp.push_back(rename_pkg::complete_t'(cmp));
        step_rel.push_back(rename_pkg::release_t'(rel));
        step_hold.push_back(hold);
        tags_left = tags_left - dest_count(g);
    endtask

    task automatic build_table();
        int k;
        add_step("reset map a", make_uop(0, 0, 0, 1, 1), make_uop(0, 0, 2, 3, 2), 0, 0, 0);
        add_step("reset map b", make_uop(0, 0, 4, 5, 3), make_uop(0, 0, 6, 7, 4), 0, 0, 0);
        add_step("lowest tags", make_uop(1, 1, 2, 3, 5), make_uop(1, 4, 5, 6, 6), 0, 0, 0);
        add_step("intra group", make_uop(1, 2, 1, 0, 7), make_uop(1, 3, 2, 2, 8), 0, 0, 0);
        add_step("double write", make_uop(1, 5, 3, 4, 9), make_uop(1, 5, 5, 1, 10), 0, 0, 0);
        add_step("read after double", make_uop(0, 0, 5, 2, 11), make_uop(0, 0, 3, 5, 12),
                 0, 0, 0);
        // valid bit on top of each record, tag below
        add_step("complete r1", make_uop(0, 0, 1, 5, 13), make_uop(0, 0, 6, 1, 14),
                 {1'b1, 5'd8}, 0, 0);
        add_step("complete r5", make_uop(0, 0, 5, 4, 15), make_uop(0, 0, 5, 0, 1),
                 {1'b1, 5'd13}, 0, 0);
        k = 0;
        while (tags_left > 1) begin
            add_step("fill", make_uop(1, core_pkg::arch_reg_t'(k % 8), 3'd1, 3'd2, 4'd2),
                     make_uop(tags_left > 2, core_pkg::arch_reg_t'((k + 3) % 8),
                              core_pkg::arch_reg_t'(k % 8), 3'd6, 4'd3), 0, 0, 0);
            k++;
        end
        // needs two tags with one left, tag 2 came back from retirement
        add_step("starved", make_uop(1, 0, 0, 1, 4), make_uop(1, 1, 2, 3, 5),
                 0, {1'b1, 5'd2}, 0);
        for (int h = 0; h < 4; h++) begin
            add_step("hold", make_uop(0, 0, core_pkg::arch_reg_t'(h), 3'd7, 4'd6),
                     make_uop(0, 0, 3'd0, core_pkg::arch_reg_t'(h + 1), 4'd7), 0, 0, 1);
        end
        add_step("drain", make_uop(0, 0, 1, 0, 8), make_uop(0, 0, 2, 5, 9), 0, 0, 0);
    endtask

    initial begin
        int   need;
        logic starved;
        int   burst;
        void'($urandom(32'ha4f6));
        rst         = 1'b1;
        in_group    = '0;
        in_valid    = 1'b0;
        out_ready   = 1'b1;
        complete    = '0;
        tag_release = '0;
        stalled     = 1'b0;
        for (int r = 0; r < core_pkg::arch_regs; r++) begin
            model_map[r].tag   = rename_pkg::phys_tag_t'(r);
            model_map[r].ready = 1'b1;
        end
        model_mask = {{(rename_pkg::phys_regs - core_pkg::arch_regs){1'b1}},
                      {core_pkg::arch_regs{1'b0}}};
        build_table();
        limit = 40 * step_name.size() + reset_cycles;
        repeat (reset_cycles) @(posedge clk);
        #5;
        rst = 1'b0;
        check_flag("reset in_ready", 1'b1, in_ready);
        check_flag("reset out_valid", 1'b0, out_valid);
        burst = 0;

        for (int s = 0; s < step_name.size(); s++) begin
            out_ready = !step_hold[s];
            if (step_cmp[s].valid) begin
                apply_complete(step_cmp[s]);
            end
            need    = dest_count(step_group[s]);
            starved = (free_count() < need);
            if (!starved) begin
                queue_expected(step_name[s], step_group[s]);
            end
            send_group(step_group[s]);
            if (starved) begin
                repeat (4) begin
                    next_cycle();
                    check_flag({step_name[s], " out_valid"}, 1'b0, out_valid);
                end
                if (!step_rel[s].valid) begin
                    $display("step %s waits for tags but has no release", step_name[s]);
                    stop_on_error();
                end
                apply_release(step_rel[s]);
                queue_expected(step_name[s], step_group[s]);
            end
            if (step_hold[s]) begin
                burst++;
                // two groups fill the output buffer, two more the input buffer
                check_flag({step_name[s], " in_ready"}, logic'(burst < 4), in_ready);
                if (!in_ready) begin
                    repeat (3) next_cycle();
                    check_flag({step_name[s], " in_ready stall"}, 1'b0, in_ready);
                end
            end else begin
                burst = 0;
                wait_drained();
                if (starved) begin
                    check_tag({step_name[s], " reuse"}, step_rel[s].tag,
                              last_group[0].dest_tag);
                end
            end
        end

        if (exp_q.size() != 0) begin
            $display("%0d expected groups never left the stage", exp_q.size());
            stop_on_error();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule
